//--- Bender.yml
package:
  name: hazdet

sources:
  # Shared package first, then the checkers and the top level
  - common/hazPkg.sv
  - hazard/stageTracker.sv
  - hazard/regHazardCheck.sv
  - hazard/memHazardCheck.sv
  - hw/hazDet.sv

  - target: test
    files:
      - verification/clkGen.sv
      - verification/hazDetTb.sv

//--- common/hazPkg.sv
package hazPkg;

    // Register file has eight entries
    localparam int RegAddrWidth = 3;
    localparam int OpcodeWidth  = 5;
    localparam int FunctWidth   = 2;
    localparam int ImmWidth     = 5;

    // Width of the class prefix at the top of the opcode
    localparam int ClassWidth = 3;

    localparam logic [OpcodeWidth-1:0] OpNop  = 5'b00001;
    localparam logic [OpcodeWidth-1:0] OpJ    = 5'b00100;
    localparam logic [OpcodeWidth-1:0] OpJr   = 5'b00101;
    localparam logic [OpcodeWidth-1:0] OpJal  = 5'b00110;
    localparam logic [OpcodeWidth-1:0] OpJalr = 5'b00111;

    // Opcode prefixes that redirect the PC
    localparam logic [ClassWidth-1:0] JumpClass   = 3'b001;
    localparam logic [ClassWidth-1:0] BranchClass = 3'b011;

    typedef struct packed {
        logic [OpcodeWidth-1:0]  opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        logic [FunctWidth-1:0]   funct;
    } rTypeT;

    typedef struct packed {
        logic [OpcodeWidth-1:0]  opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rd;
        logic [ImmWidth-1:0]     imm;
    } iTypeT;

    // Same 16-bit word, decoded as register or immediate form
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrT;

    // What an instruction leaves behind in a pipeline stage
    typedef struct packed {
        logic [RegAddrWidth-1:0] rd;
        logic                    writesReg;
        logic                    memEnable;
    } stageTagT;

    typedef struct packed {
        stageTagT id;
        stageTagT ex;
        stageTagT mem;
        stageTagT wb;
    } stageTagsT;

    typedef struct packed {
        logic exToExRs;
        logic memToExRs;
        logic exToExRt;
        logic memToExRt;
        logic exToIdRs;
        logic memToIdRs;
    } forwardsT;

endpackage

//--- hazard/memHazardCheck.sv
module memHazardCheck import hazPkg::*; #(
    parameter int AddrWidth = 16
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [AddrWidth-1:0] reg1Data,
    input  logic [AddrWidth-1:0] imm,
    input  logic                 memEnable,
    input  logic                 insertBubble,
    input  stageTagsT            tags,
    output logic                 memHaz
);

    // ID, EX, MEM and WB
    localparam int NumStages = 4;
    // WB has finished its access and is not compared
    localparam int NumChecked = 3;

    logic [AddrWidth-1:0]                 memAddr;
    logic [NumStages-1:0][AddrWidth-1:0] stageAddr;
    logic [NumChecked-1:0]                stageMemEn;
    logic [NumChecked-1:0]                addrHit;

    // Base plus offset wraps at the address width
    assign memAddr = reg1Data + imm;

    // Address travels next to its tag
    // Index 0 is ID
    // Shifted even on a bubble since the cleared tag masks it
    always_ff @(posedge clk) begin
        stageAddr <= {stageAddr[NumStages-2:0], memAddr};
    end

    assign stageMemEn = {tags.mem.memEnable, tags.ex.memEnable, tags.id.memEnable};

    always_comb begin
        for (int i = 0; i < NumChecked; i++) begin
            addrHit[i] = stageMemEn[i] && (stageAddr[i] == memAddr);
        end
    end

    assign memHaz = memEnable && (|addrHit);

    property hazNeedsAccess;
        @(posedge clk) disable iff (!arstN)
            memHaz |-> memEnable;
    endproperty

    hazNeedsAccessA : assert property (hazNeedsAccess)
        else $error("memHazardCheck: conflict without memory access");

endmodule

//--- hazard/regHazardCheck.sv
module regHazardCheck import hazPkg::*; (
    input  instrT     instr,
    input  stageTagsT tags,
    output forwardsT  forwards,
    output logic      regHaz
);

    logic [OpcodeWidth-1:0]  opcode;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;

    logic isJr;
    logic readsRs;
    logic readsRt;

    // Writers of rs and rt, one flag per stage
    logic idWritesRs;
    logic idWritesRt;
    logic exWritesRs;
    logic exWritesRt;
    logic memWritesRs;

    logic loadUse;
    logic jrHaz;

    assign opcode = instr.rType.opcode;
    assign rs     = instr.rType.rs;
    assign rt     = instr.rType.rt;

    // Operand usage by opcode
    always_comb begin
        isJr    = (opcode == OpJr) || (opcode == OpJalr);
        readsRs = !((opcode == OpNop) || (opcode == OpJ) || (opcode == OpJal));
        // JR and JALR only need the jump target in rs
        readsRt = readsRs && !isJr;
    end

    assign idWritesRs  = tags.id.writesReg  && (tags.id.rd  == rs);
    assign idWritesRt  = tags.id.writesReg  && (tags.id.rd  == rt);
    assign exWritesRs  = tags.ex.writesReg  && (tags.ex.rd  == rs);
    assign exWritesRt  = tags.ex.writesReg  && (tags.ex.rd  == rt);
    assign memWritesRs = tags.mem.writesReg && (tags.mem.rd == rs);

    // Paths into EX, taken by the instruction when it reaches EX
    // A load one ahead has no data yet at the end of EX
    always_comb begin
        forwards.exToExRs  = readsRs && idWritesRs && !tags.id.memEnable;
        forwards.memToExRs = readsRs && exWritesRs;
        forwards.exToExRt  = readsRt && idWritesRt && !tags.id.memEnable;
        forwards.memToExRt = readsRt && exWritesRt;
    end

    // JR and JALR resolve their target in ID, so the paths point there
    always_comb begin
        forwards.exToIdRs  = isJr && exWritesRs && !tags.ex.memEnable;
        forwards.memToIdRs = isJr && memWritesRs;
    end

    // Load directly ahead of a reader
    assign loadUse = tags.id.memEnable &&
                     ((readsRs && idWritesRs) || (readsRt && idWritesRt));

    // Jump target still in EX, or a load two ahead
    assign jrHaz = isJr && (idWritesRs || (exWritesRs && tags.ex.memEnable));

    assign regHaz = isJr ? jrHaz : loadUse;

    // Plain jumps read no register and can never wait on one
    always_comb begin
        noStallOnJ : assert final (!(regHaz && (opcode == OpJ)))
            else $error("regHazardCheck: stall raised for J");
    end

endmodule

//--- hazard/stageTracker.sv
module stageTracker import hazPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [RegAddrWidth-1:0] rd,
    input  logic                    writesReg,
    input  logic                    memEnable,
    input  logic                    insertBubble,
    output stageTagsT               tags
);

    stageTagT  issueTag;
    stageTagsT tagsQ;

    // Tag of the instruction being issued this cycle
    always_comb begin
        issueTag.rd        = rd;
        issueTag.writesReg = writesReg;
        issueTag.memEnable = memEnable;

        // A bubble takes the issue slot, so nothing is written and memory is untouched
        if (insertBubble) begin
            issueTag = '0;
        end
    end

    // Shadow of the ID, EX, MEM and WB stage registers
    // Stages never hold, a stall shows up only as an empty tag
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tagsQ <= '0;
        end else begin
            tagsQ.id  <= issueTag;
            tagsQ.ex  <= tagsQ.id;
            tagsQ.mem <= tagsQ.ex;
            tagsQ.wb  <= tagsQ.mem;
        end
    end

    assign tags = tagsQ;

    // The slot freed by a bubble must not look like a writer one stage later
    property bubbleClearsId;
        @(posedge clk) disable iff (!arstN)
            insertBubble |=> (tags.id == '0);
    endproperty

    bubbleClearsIdA : assert property (bubbleClearsId)
        else $error("stageTracker: ID tag not empty after bubble");

endmodule

//--- hw/hazDet.sv
module hazDet import hazPkg::*; #(
    parameter int AddrWidth = 16
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  instrT                   instr,
    input  logic [RegAddrWidth-1:0] rd,
    input  logic                    writesReg,
    input  logic                    memEnable,
    input  logic [AddrWidth-1:0]    reg1Data,
    input  logic [AddrWidth-1:0]    imm,
    output logic                    nop,
    output logic                    pcStall,
    output forwardsT                forwards
);

    stageTagsT tags;

    logic regHaz;
    logic memHaz;
    logic stall;
    logic insertBubble;

    logic [ClassWidth-1:0] opClass;
    logic isNop;
    logic isJumpBranch;
    logic branchBubble;

    stageTracker stageTracker_i (
        .clk          (clk),
        .arstN        (arstN),
        .rd           (rd),
        .writesReg    (writesReg),
        .memEnable    (memEnable),
        .insertBubble (insertBubble),
        .tags         (tags)
    );

    regHazardCheck regHazardCheck_i (
        .instr    (instr),
        .tags     (tags),
        .forwards (forwards),
        .regHaz   (regHaz)
    );

    memHazardCheck #(
        .AddrWidth (AddrWidth)
    ) memHazardCheck_i (
        .clk          (clk),
        .arstN        (arstN),
        .reg1Data     (reg1Data),
        .imm          (imm),
        .memEnable    (memEnable),
        .insertBubble (insertBubble),
        .tags         (tags),
        .memHaz       (memHaz)
    );

    assign opClass      = instr.rType.opcode[OpcodeWidth-1 -: ClassWidth];
    assign isNop        = (instr.rType.opcode == OpNop);
    assign isJumpBranch = (opClass == JumpClass) || (opClass == BranchClass);

    assign stall = regHaz || memHaz;

    // The fetch behind a jump or branch is dropped once
    // Not armed while stalled, the jump comes back next cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            branchBubble <= 1'b0;
        end else begin
            branchBubble <= isJumpBranch && !stall;
        end
    end

    // A NOP in the issue slot is already a bubble
    assign pcStall = stall && !isNop;
    assign nop     = (stall || branchBubble) && !isNop;

    assign insertBubble = nop;

    // Holding the PC without a bubble would issue the instruction twice
    property stallGivesBubble;
        @(posedge clk) disable iff (!arstN)
            pcStall |-> nop;
    endproperty

    stallGivesBubbleA : assert property (stallGivesBubble)
        else $error("hazDet: PC held without bubble");

endmodule

//--- sim.f
common/hazPkg.sv
hazard/stageTracker.sv
hazard/regHazardCheck.sv
hazard/memHazardCheck.sv
hw/hazDet.sv
verification/clkGen.sv
verification/hazDetTb.sv

//--- verification/clkGen.sv
module clkGen #(
    parameter int Period      = 100,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Reset held for a few rising edges, released away from them
    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

//--- verification/hazDetTb.sv
module hazDetTb import hazPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int Period       = 100;
    localparam int AddrWidth    = 16;
    localparam int ResetTimeout = 20;
    localparam int MaxCycles    = 400;

    // Opcodes outside the named set
    // Class comes from the top three bits
    localparam logic [4:0] OpAlu    = 5'b10000;
    localparam logic [4:0] OpLoad   = 5'b10100;
    localparam logic [4:0] OpStore  = 5'b10110;
    localparam logic [4:0] OpBranch = 5'b01100;

    logic                 clk;
    logic                 arstN;
    instrT                instr;
    logic [2:0]           rd;
    logic                 writesReg;
    logic                 memEnable;
    logic [AddrWidth-1:0] reg1Data;
    logic [AddrWidth-1:0] imm;
    logic                 nop;
    logic                 pcStall;
    forwardsT             forwards;

    // Reference pipeline with ID at index 0
    logic [2:0]           modelRd   [4];
    logic                 modelWr   [4];
    logic                 modelMem  [4];
    logic [AddrWidth-1:0] modelAddr [4];
    logic                 modelBubble;

    // Outputs seen in the last issue cycle
    logic     gotNop;
    logic     gotStall;
    forwardsT gotFwd;

    int          checkCount;
    int          errorCount;
    int          waitCycles;
    logic [31:0] lfsrState;

    clkGen #(
        .Period      (Period),
        .ResetCycles (4)
    ) clkGen_i (
        .clk   (clk),
        .arstN (arstN)
    );

    hazDet #(
        .AddrWidth (AddrWidth)
    ) hazDet_i (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .rd        (rd),
        .writesReg (writesReg),
        .memEnable (memEnable),
        .reg1Data  (reg1Data),
        .imm       (imm),
        .nop       (nop),
        .pcStall   (pcStall),
        .forwards  (forwards)
    );

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic feedback;
        feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], feedback};
    endfunction

    task automatic randomWord(output logic [AddrWidth-1:0] w);
        for (int b = 0; b < AddrWidth; b++) begin
            lfsrState = lfsrNext(lfsrState);
            w[b] = lfsrState[0];
        end
    endtask

    function automatic instrT regForm(input logic [4:0] op, input logic [2:0] rs,
                                      input logic [2:0] rt);
        instrT w;
        w = '0;
        w.rType.opcode = op;
        w.rType.rs     = rs;
        w.rType.rt     = rt;
        return w;
    endfunction

    function automatic instrT immForm(input logic [4:0] op, input logic [2:0] rs,
                                      input logic [2:0] dest, input logic [4:0] offset);
        instrT w;
        w.iType.opcode = op;
        w.iType.rs     = rs;
        w.iType.rd     = dest;
        w.iType.imm    = offset;
        return w;
    endfunction

    // Drives one issue slot and checks all outputs before the reference pipeline advances
    task automatic issue(input instrT ins, input logic [2:0] dest, input logic wr,
                         input logic mem, input logic [AddrWidth-1:0] base,
                         input logic [AddrWidth-1:0] offset);
        logic [4:0]           op;
        logic [2:0]           rs;
        logic [2:0]           rt;
        logic [AddrWidth-1:0] addr;
        logic                 isJr;
        logic                 readsRs;
        logic                 readsRt;
        logic                 regStall;
        logic                 memStall;
        logic                 expNop;
        logic                 expStall;
        forwardsT             expFwd;

        @(negedge clk);
        instr     = ins;
        rd        = dest;
        writesReg = wr;
        memEnable = mem;
        reg1Data  = base;
        imm       = offset;
        #(Period / 4);

        op      = ins.rType.opcode;
        rs      = ins.rType.rs;
        rt      = ins.rType.rt;
        addr    = base + offset;
        isJr    = (op == OpJr) || (op == OpJalr);
        readsRs = !(op inside {OpNop, OpJ, OpJal});
        readsRt = readsRs && !isJr;

        expFwd.exToExRs  = readsRs && modelWr[0] && (modelRd[0] == rs) && !modelMem[0];
        expFwd.memToExRs = readsRs && modelWr[1] && (modelRd[1] == rs);
        expFwd.exToExRt  = readsRt && modelWr[0] && (modelRd[0] == rt) && !modelMem[0];
        expFwd.memToExRt = readsRt && modelWr[1] && (modelRd[1] == rt);
        expFwd.exToIdRs  = isJr && modelWr[1] && (modelRd[1] == rs) && !modelMem[1];
        expFwd.memToIdRs = isJr && modelWr[2] && (modelRd[2] == rs);

        if (isJr) begin
            regStall = (modelWr[0] && (modelRd[0] == rs)) ||
                       (modelWr[1] && modelMem[1] && (modelRd[1] == rs));
        end else begin
            regStall = modelWr[0] && modelMem[0] &&
                       ((readsRs && (modelRd[0] == rs)) || (readsRt && (modelRd[0] == rt)));
        end

        memStall = 1'b0;
        for (int s = 0; s < 3; s++) begin
            if (mem && modelMem[s] && (modelAddr[s] == addr)) begin
                memStall = 1'b1;
            end
        end

        expStall = (regStall || memStall) && (op != OpNop);
        expNop   = (regStall || memStall || modelBubble) && (op != OpNop);

        gotNop   = nop;
        gotStall = pcStall;
        gotFwd   = forwards;
        check(nop, expNop, "nop");
        check(pcStall, expStall, "pcStall");
        check(forwards, expFwd, "forwards");

        // State after the coming rising edge
        modelBubble = ((op[4:2] == 3'b001) || (op[4:2] == 3'b011)) && !(regStall || memStall);
        for (int s = 3; s > 0; s--) begin
            modelRd[s]   = modelRd[s-1];
            modelWr[s]   = modelWr[s-1];
            modelMem[s]  = modelMem[s-1];
            modelAddr[s] = modelAddr[s-1];
        end
        modelRd[0]   = expNop ? 3'd0 : dest;
        modelWr[0]   = expNop ? 1'b0 : wr;
        modelMem[0]  = expNop ? 1'b0 : mem;
        modelAddr[0] = addr;
    endtask

    task automatic drainPipeline();
        repeat (4) issue(regForm(OpNop, 0, 0), 0, 0, 0, 0, 0);
    endtask

    task automatic reportTest(input string name, input int startErrors);
        $display("%s finished with %0d mismatches", name, errorCount - startErrors);
    endtask

    task automatic resetAndNop();
        int start;
        start = errorCount;
        issue(regForm(OpNop, 0, 0), 0, 0, 0, 0, 0);
        check(gotNop, 0, "nop after reset");
        check(gotStall, 0, "pcStall after reset");
        check(gotFwd, 0, "forwards after reset");
        // Load r1 followed by a NOP that names r1 and the same address
        issue(immForm(OpLoad, 0, 1, 0), 1, 1, 1, 16'h0040, 0);
        issue(regForm(OpNop, 1, 1), 0, 0, 1, 16'h0040, 0);
        check(gotNop, 0, "nop on colliding NOP");
        check(gotStall, 0, "pcStall on colliding NOP");
        reportTest("resetAndNop", start);
    endtask

    task automatic aluForwarding();
        int start;
        start = errorCount;
        drainPipeline();
        issue(regForm(OpAlu, 0, 0), 3, 1, 0, 0, 0);
        issue(regForm(OpAlu, 3, 0), 0, 0, 0, 0, 0);
        check(gotFwd.exToExRs, 1, "exToExRs one behind");
        issue(regForm(OpAlu, 3, 0), 0, 0, 0, 0, 0);
        check(gotFwd.memToExRs, 1, "memToExRs two behind");
        check(gotFwd.exToExRs, 0, "exToExRs two behind");
        drainPipeline();
        issue(regForm(OpAlu, 0, 0), 4, 1, 0, 0, 0);
        issue(regForm(OpAlu, 0, 4), 0, 0, 0, 0, 0);
        check(gotFwd.exToExRt, 1, "exToExRt one behind");
        issue(regForm(OpAlu, 0, 4), 0, 0, 0, 0, 0);
        check(gotFwd.memToExRt, 1, "memToExRt two behind");
        check(gotStall, 0, "pcStall on ALU forwarding");
        reportTest("aluForwarding", start);
    endtask

    task automatic loadUse();
        int start;
        start = errorCount;
        drainPipeline();
        issue(immForm(OpLoad, 0, 2, 0), 2, 1, 1, 16'h0100, 0);
        issue(regForm(OpAlu, 2, 0), 0, 0, 0, 0, 0);
        check(gotNop, 1, "nop on load-use");
        check(gotStall, 1, "pcStall on load-use");
        // Reader presented again once the load has reached EX
        issue(regForm(OpAlu, 2, 0), 0, 0, 0, 0, 0);
        check(gotNop, 0, "nop on retried reader");
        check(gotStall, 0, "pcStall on retried reader");
        check(gotFwd.memToExRs, 1, "memToExRs on retried reader");
        reportTest("loadUse", start);
    endtask

    task automatic jumpRegister();
        int start;
        start = errorCount;
        drainPipeline();
        issue(regForm(OpAlu, 0, 0), 2, 1, 0, 0, 0);
        issue(regForm(OpJr, 2, 0), 0, 0, 0, 0, 0);
        check(gotStall, 1, "pcStall on JR one behind");
        drainPipeline();
        issue(regForm(OpAlu, 0, 0), 2, 1, 0, 0, 0);
        issue(regForm(OpAlu, 0, 0), 0, 0, 0, 0, 0);
        issue(regForm(OpJr, 2, 0), 0, 0, 0, 0, 0);
        check(gotFwd.exToIdRs, 1, "exToIdRs on JR two behind");
        check(gotStall, 0, "pcStall on JR two behind");
        drainPipeline();
        issue(regForm(OpAlu, 0, 0), 2, 1, 0, 0, 0);
        issue(regForm(OpAlu, 0, 0), 0, 0, 0, 0, 0);
        issue(regForm(OpAlu, 0, 0), 0, 0, 0, 0, 0);
        issue(regForm(OpJalr, 2, 0), 0, 0, 0, 0, 0);
        check(gotFwd.memToIdRs, 1, "memToIdRs on JALR three behind");
        check(gotStall, 0, "pcStall on JALR three behind");
        reportTest("jumpRegister", start);
    endtask

    task automatic memoryConflict();
        int                   start;
        logic [AddrWidth-1:0] base;
        start = errorCount;
        drainPipeline();
        randomWord(base);
        issue(regForm(OpStore, 1, 1), 0, 0, 1, base, 16'h0005);
        issue(immForm(OpLoad, 1, 6, 5), 6, 1, 1, base, 16'h0005);
        check(gotStall, 1, "pcStall on load after store to same address");
        drainPipeline();
        randomWord(base);
        issue(regForm(OpStore, 1, 1), 0, 0, 1, base, 16'h0005);
        issue(immForm(OpLoad, 1, 6, 5), 6, 1, 1, base + 1'b1, 16'h0005);
        check(gotStall, 0, "pcStall on load to other address");
        check(gotNop, 0, "nop on load to other address");
        reportTest("memoryConflict", start);
    endtask

    task automatic branchShadow();
        int start;
        start = errorCount;
        drainPipeline();
        issue(regForm(OpBranch, 0, 0), 0, 0, 0, 0, 0);
        check(gotNop, 0, "nop in branch cycle");
        check(gotStall, 0, "pcStall in branch cycle");
        issue(regForm(OpAlu, 0, 0), 0, 0, 0, 0, 0);
        check(gotNop, 1, "nop after branch");
        check(gotStall, 0, "pcStall after branch");
        issue(regForm(OpAlu, 0, 0), 0, 0, 0, 0, 0);
        check(gotNop, 0, "nop two after branch");
        reportTest("branchShadow", start);
    endtask

    // Upper bound on the whole run
    initial begin
        #(MaxCycles * Period);
        $display("Simulation did not finish within %0d cycles", MaxCycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        instr       = regForm(OpNop, 0, 0);
        rd          = '0;
        writesReg   = 1'b0;
        memEnable   = 1'b0;
        reg1Data    = '0;
        imm         = '0;
        checkCount  = 0;
        errorCount  = 0;
        lfsrState   = 32'h9be0ef2c;
        modelBubble = 1'b0;
        for (int s = 0; s < 4; s++) begin
            modelRd[s]   = '0;
            modelWr[s]   = 1'b0;
            modelMem[s]  = 1'b0;
            modelAddr[s] = '0;
        end

        waitCycles = 0;
        while (!arstN && (waitCycles < ResetTimeout)) begin
            @(posedge clk);
            waitCycles++;
        end

        if (!arstN) begin
            $display("Reset was never released");
            $display("Test FAILED");
        end else begin
            resetAndNop();
            aluForwarding();
            loadUse();
            jumpRegister();
            memoryConflict();
            branchShadow();
            $display("Summary: %0d checks, %0d mismatches", checkCount, errorCount);
            if (errorCount == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
        end
        $finish;
    end

endmodule
